//--- design/fmul_config.svh
// ----------------------------------------
// Binary16 multiplier format constants
// Field widths, bias and datapath widths
// ----------------------------------------
`ifndef FMUL_CONFIG_SVH
`define FMUL_CONFIG_SVH

// IEEE 754 binary16 encoding
`define FMUL_EXP_BITS   5
`define FMUL_MAN_BITS   10
`define FMUL_WIDTH      16
`define FMUL_BIAS       15

// Significand precision with the implicit bit
`define FMUL_PREC_BITS  11
// Signed internal exponent, two bits wider than the field
`define FMUL_EXP_WIDTH  7
// Full p x p significand product
`define FMUL_PROD_WIDTH 22

`endif

//--- design/fmul_operand_stage.sv
// ----------------------------------------
// Binary16 multiplier operand stage
// Classifies both operands, resolves special
// cases, forms product exponent and the
// full significand product
// ----------------------------------------
`timescale 1ns/1ps
`include "fmul_config.svh"

module fmul_operand_stage (
  input  fmul_pkg::fp16_u                          operand_a_i,
  input  fmul_pkg::fp16_u                          operand_b_i,
  input  fmul_pkg::roundmode_e                     rnd_mode_i,
  output logic                                     special_o,
  output fmul_pkg::fp16_u                          special_result_o,
  output fmul_pkg::status_t                        special_status_o,
  output logic                                     sign_o,
  output logic signed [`FMUL_EXP_WIDTH-1:0]        exponent_o,
  output logic        [`FMUL_PROD_WIDTH-1:0]       product_o,
  output fmul_pkg::roundmode_e                     rnd_mode_o
);

  import fmul_pkg::*;

  localparam int unsigned EW = `FMUL_EXP_WIDTH;
  // Biased exponent of a zero product, the smallest reachable value
  localparam logic signed [EW-1:0] ZERO_EXP = EW'(2 - `FMUL_BIAS);
  localparam logic signed [EW-1:0] BIAS_S   = EW'(`FMUL_BIAS);

  // Classify one operand from its fields
  function automatic fp_class_t classify(input fp16_fields_t f);
    fp_class_t c;
    logic      exp_zero;
    logic      exp_ones;
    logic      man_zero;
    exp_zero = (f.exponent == '0);
    exp_ones = (f.exponent == '1);
    man_zero = (f.mantissa == '0);
    c.is_normal     = !exp_zero && !exp_ones;
    c.is_subnormal  = exp_zero && !man_zero;
    c.is_zero       = exp_zero && man_zero;
    c.is_inf        = exp_ones && man_zero;
    c.is_nan        = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    c.is_signalling = c.is_nan && !f.mantissa[`FMUL_MAN_BITS-1];
    return c;
  endfunction

  fp16_fields_t a;
  fp16_fields_t b;
  fp_class_t    cls_a;
  fp_class_t    cls_b;
  logic         product_sign;

  assign a     = operand_a_i.fields;
  assign b     = operand_b_i.fields;
  assign cls_a = classify(a);
  assign cls_b = classify(b);

  // Sign of every product, zeros included
  assign product_sign = a.sign ^ b.sign;

  // ----------------------------------------
  // Special cases
  // ----------------------------------------
  always_comb begin : special_cases
    // Canonical quiet NaN unless an infinity wins below
    special_result_o.fields = '{
      sign:     1'b0,
      exponent: '1,
      mantissa: {1'b1, {(`FMUL_MAN_BITS-1){1'b0}}}
    };
    special_status_o = '0;
    special_o        = 1'b0;

    if ((cls_a.is_inf && cls_b.is_zero) || (cls_a.is_zero && cls_b.is_inf)) begin
      // Infinity times zero is invalid
      special_o           = 1'b1;
      special_status_o.NV = 1'b1;
    end else if (cls_a.is_nan || cls_b.is_nan) begin
      // NaN propagates as qNaN, NV only for a signalling input
      special_o           = 1'b1;
      special_status_o.NV = cls_a.is_signalling || cls_b.is_signalling;
    end else if (cls_a.is_inf || cls_b.is_inf) begin
      // Infinity times finite nonzero
      special_o               = 1'b1;
      special_result_o.fields = '{sign: product_sign, exponent: '1, mantissa: '0};
    end
  end

  // ----------------------------------------
  // Exponent and significand product
  // ----------------------------------------
  logic signed [EW-1:0]                  exp_a;
  logic signed [EW-1:0]                  exp_b;
  logic        [`FMUL_PREC_BITS-1:0]     mant_a;
  logic        [`FMUL_PREC_BITS-1:0]     mant_b;

  // Subnormals count as encoded exponent 1
  assign exp_a = $signed({{(EW-`FMUL_EXP_BITS){1'b0}}, a.exponent})
               + $signed({{(EW-1){1'b0}}, cls_a.is_subnormal});
  assign exp_b = $signed({{(EW-`FMUL_EXP_BITS){1'b0}}, b.exponent})
               + $signed({{(EW-1){1'b0}}, cls_b.is_subnormal});

  // Sum of biased exponents keeps one bias
  assign exponent_o = (cls_a.is_zero || cls_b.is_zero) ? ZERO_EXP
                                                       : exp_a + exp_b - BIAS_S;

  // Implicit bit is set for normal operands only
  assign mant_a = {cls_a.is_normal, a.mantissa};
  assign mant_b = {cls_b.is_normal, b.mantissa};

  // Product lies in [0, 4) with 2*MAN_BITS fraction bits
  assign product_o = mant_a * mant_b;

  assign sign_o     = product_sign;
  assign rnd_mode_o = rnd_mode_i;

endmodule

//--- design/fmul_pkg.sv
// ----------------------------------------
// Binary16 multiplier shared types
// Operand view, rounding modes and flags
// ----------------------------------------
`include "fmul_config.svh"

package fmul_pkg;

  // Operand fields in IEEE bit order
  typedef struct packed {
    logic                      sign;
    logic [`FMUL_EXP_BITS-1:0] exponent;
    logic [`FMUL_MAN_BITS-1:0] mantissa;
  } fp16_fields_t;

  // Same word, raw at the ports and split in the datapath
  typedef union packed {
    logic [`FMUL_WIDTH-1:0] raw;
    fp16_fields_t           fields;
  } fp16_u;

  // RISC-V style rounding mode encodings
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  // Exception flags, no DZ in a multiplier
  typedef struct packed {
    logic NV;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Operand classification
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_class_t;

endpackage

//--- design/fmul_round_stage.sv
// ----------------------------------------
// Binary16 multiplier rounding stage
// Normalizes the product, handles subnormal
// results, rounds in five modes, raises
// flags and selects the final result
// ----------------------------------------
`timescale 1ns/1ps
`include "fmul_config.svh"

module fmul_round_stage (
  input  logic                               special_i,
  input  fmul_pkg::fp16_u                    special_result_i,
  input  fmul_pkg::status_t                  special_status_i,
  input  logic                               sign_i,
  input  logic signed [`FMUL_EXP_WIDTH-1:0]  exponent_i,
  input  logic        [`FMUL_PROD_WIDTH-1:0] product_i,
  input  fmul_pkg::roundmode_e               rnd_mode_i,
  output fmul_pkg::fp16_u                    result_o,
  output fmul_pkg::status_t                  status_o
);

  import fmul_pkg::*;

  localparam int unsigned PW  = `FMUL_PROD_WIDTH;
  localparam int unsigned EW  = `FMUL_EXP_WIDTH;
  localparam int unsigned AW  = `FMUL_EXP_BITS + `FMUL_MAN_BITS;
  // Zero headroom above the product for right alignment of tiny results
  localparam int unsigned PAD = `FMUL_PREC_BITS + 3;
  localparam int unsigned VW  = PW + PAD;
  localparam int unsigned SHW = $clog2(VW);
  localparam int unsigned LZW = $clog2(PW);
  // Implicit bit, mantissa and round bit
  localparam int unsigned MW  = `FMUL_PREC_BITS + 1;
  localparam int unsigned STICKY_TOP = VW - MW - 2;
  localparam logic signed [EW-1:0] SUB_OFFSET = EW'(PAD - 1);
  localparam logic signed [EW-1:0] EXP_INF    = EW'((1 << `FMUL_EXP_BITS) - 1);

  // Leading zeros below the carry position of the product
  function automatic logic [LZW-1:0] count_lz(input logic [PW-2:0] value);
    logic [LZW-1:0] count;
    logic           found;
    count = LZW'(PW - 1);
    found = 1'b0;
    for (int i = PW - 2; i >= 0; i--) begin
      if (value[i] && !found) begin
        count = LZW'(PW - 2 - i);
        found = 1'b1;
      end
    end
    return count;
  endfunction

  // ----------------------------------------
  // Normalization
  // ----------------------------------------
  logic                 carry;
  logic [LZW-1:0]       lz;
  logic [LZW-1:0]       lz_eff;
  logic signed [EW-1:0] lz_s;
  logic                 normal_result;
  logic [SHW-1:0]       norm_shamt;
  logic signed [EW-1:0] norm_exponent;
  logic [VW-1:0]        shifted;
  logic [VW-1:0]        norm_vec;
  logic signed [EW-1:0] final_exponent;
  logic [MW-1:0]        final_mantissa;
  logic                 sticky;

  // Product MSB set means a value in [2, 4)
  assign carry  = product_i[PW-1];
  assign lz     = count_lz(product_i[PW-2:0]);
  assign lz_eff = carry ? '0 : lz;
  assign lz_s   = $signed({{(EW-LZW){1'b0}}, lz_eff});

  // Result stays normal if the exponent after the shift is at least 1
  assign normal_result = carry ? (exponent_i >= 0)
                               : ((|product_i) && (exponent_i - lz_s >= 1));

  always_comb begin : norm_shift_amount
    if (normal_result) begin
      // Leading one lands on the implicit bit position
      norm_shamt    = SHW'(PAD) + SHW'(lz_eff);
      norm_exponent = exponent_i - lz_s;
    end else begin
      // Cap the shift so the mantissa sits at exponent 1, encoded as 0
      norm_shamt    = SHW'(exponent_i + SUB_OFFSET);
      norm_exponent = '0;
    end
  end

  assign shifted = {{PAD{1'b0}}, product_i} << norm_shamt;

  // 1-bit correction when the product was in [2, 4)
  always_comb begin : carry_fix
    if (shifted[VW-1]) begin
      norm_vec       = shifted >> 1;
      final_exponent = norm_exponent + EW'(1);
    end else begin
      norm_vec       = shifted;
      final_exponent = norm_exponent;
    end
  end

  assign final_mantissa = norm_vec[VW-2 -: MW];
  assign sticky         = |norm_vec[STICKY_TOP:0];

  // ----------------------------------------
  // Rounding
  // ----------------------------------------
  logic                      of_before;
  logic                      of_after;
  logic                      tiny_after;
  logic [`FMUL_EXP_BITS-1:0] pre_round_exponent;
  logic [`FMUL_MAN_BITS-1:0] pre_round_mantissa;
  logic [AW-1:0]             pre_round_abs;
  logic [1:0]                round_sticky;
  logic                      round_up;
  logic [AW-1:0]             rounded_abs;
  status_t                   regular_status;

  assign of_before = (final_exponent >= EXP_INF);

  // Overflow starts from the largest finite value, mode picks inf or not
  assign pre_round_exponent = of_before ? `FMUL_EXP_BITS'((1 << `FMUL_EXP_BITS) - 2)
                                        : final_exponent[`FMUL_EXP_BITS-1:0];
  assign pre_round_mantissa = of_before ? '1 : final_mantissa[MW-2:1];
  assign pre_round_abs      = {pre_round_exponent, pre_round_mantissa};
  assign round_sticky       = of_before ? 2'b11 : {final_mantissa[0], sticky};

  always_comb begin : round_decision
    case (rnd_mode_i)
      // Ties go to the even LSB
      RNE:     round_up = round_sticky[1] & (round_sticky[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) & sign_i;
      RUP:     round_up = (|round_sticky) & ~sign_i;
      // Ties away from zero
      RMM:     round_up = round_sticky[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent field
  assign rounded_abs = pre_round_abs + {{(AW-1){1'b0}}, round_up};

  assign of_after = (rounded_abs[AW-1 -: `FMUL_EXP_BITS] == '1);

  // Tiny after rounding unless unbounded-exponent rounding reaches 2^emin
  assign tiny_after = (rounded_abs[AW-1 -: `FMUL_EXP_BITS] == '0)
                   || ((pre_round_exponent == '0)
                       && (rounded_abs[AW-1 -: `FMUL_EXP_BITS] == `FMUL_EXP_BITS'(1))
                       && ((round_sticky != 2'b11)
                           || (!norm_vec[STICKY_TOP]
                               && ((rnd_mode_i == RNE) || (rnd_mode_i == RMM)))));

  // ----------------------------------------
  // Flags and result selection
  // ----------------------------------------
  assign regular_status.NV = 1'b0;
  assign regular_status.OF = of_before | of_after;
  assign regular_status.NX = (|round_sticky) | of_before | of_after;
  // Underflow only for inexact tiny results
  assign regular_status.UF = tiny_after & regular_status.NX;

  assign result_o.raw = special_i ? special_result_i.raw : {sign_i, rounded_abs};
  assign status_o     = special_i ? special_status_i : regular_status;

endmodule

//--- design/fmul_stage_reg.sv
// ----------------------------------------
// Binary16 multiplier stage register
// Holds one product between operand and
// rounding stages
// ----------------------------------------
`timescale 1ns/1ps
`include "fmul_config.svh"

module fmul_stage_reg (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // From the operand stage
  input  logic                               special_i,
  input  fmul_pkg::fp16_u                    special_result_i,
  input  fmul_pkg::status_t                  special_status_i,
  input  logic                               sign_i,
  input  logic signed [`FMUL_EXP_WIDTH-1:0]  exponent_i,
  input  logic        [`FMUL_PROD_WIDTH-1:0] product_i,
  input  fmul_pkg::roundmode_e               rnd_mode_i,
  // To the rounding stage
  output logic                               special_o,
  output fmul_pkg::fp16_u                    special_result_o,
  output fmul_pkg::status_t                  special_status_o,
  output logic                               sign_o,
  output logic signed [`FMUL_EXP_WIDTH-1:0]  exponent_o,
  output logic        [`FMUL_PROD_WIDTH-1:0] product_o,
  output fmul_pkg::roundmode_e               rnd_mode_o
);

  import fmul_pkg::*;

  // ----------------------------------------
  // Pipeline register, loads every cycle
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Zero product with clear flags, rounds to +0 without exceptions
      special_o        <= 1'b0;
      special_result_o <= '0;
      special_status_o <= '0;
      sign_o           <= 1'b0;
      exponent_o       <= '0;
      product_o        <= '0;
      rnd_mode_o       <= RNE;
    end else begin
      special_o        <= special_i;
      special_result_o <= special_result_i;
      special_status_o <= special_status_i;
      sign_o           <= sign_i;
      exponent_o       <= exponent_i;
      product_o        <= product_i;
      rnd_mode_o       <= rnd_mode_i;
    end
  end

endmodule

//--- design/fmul_top.sv
// ----------------------------------------
// Binary16 multiplier top level
// Operand stage, one register, rounding
// ----------------------------------------
`timescale 1ns/1ps
`include "fmul_config.svh"

module fmul_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [`FMUL_WIDTH-1:0]     operand_a_i,
  input  logic [`FMUL_WIDTH-1:0]     operand_b_i,
  input  fmul_pkg::roundmode_e       rnd_mode_i,
  output logic [`FMUL_WIDTH-1:0]     result_o,
  output fmul_pkg::status_t          status_o
);

  import fmul_pkg::*;

  // Operand stage outputs
  logic                              op_special;
  fp16_u                             op_special_result;
  status_t                           op_special_status;
  logic                              op_sign;
  logic signed [`FMUL_EXP_WIDTH-1:0] op_exponent;
  logic [`FMUL_PROD_WIDTH-1:0]       op_product;
  roundmode_e                        op_rnd_mode;

  // Registered copies
  logic                              reg_special;
  fp16_u                             reg_special_result;
  status_t                           reg_special_status;
  logic                              reg_sign;
  logic signed [`FMUL_EXP_WIDTH-1:0] reg_exponent;
  logic [`FMUL_PROD_WIDTH-1:0]       reg_product;
  roundmode_e                        reg_rnd_mode;

  fmul_operand_stage operand_stage_i (
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .rnd_mode_i       (rnd_mode_i),
    .special_o        (op_special),
    .special_result_o (op_special_result),
    .special_status_o (op_special_status),
    .sign_o           (op_sign),
    .exponent_o       (op_exponent),
    .product_o        (op_product),
    .rnd_mode_o       (op_rnd_mode)
  );

  fmul_stage_reg stage_reg_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .special_i        (op_special),
    .special_result_i (op_special_result),
    .special_status_i (op_special_status),
    .sign_i           (op_sign),
    .exponent_i       (op_exponent),
    .product_i        (op_product),
    .rnd_mode_i       (op_rnd_mode),
    .special_o        (reg_special),
    .special_result_o (reg_special_result),
    .special_status_o (reg_special_status),
    .sign_o           (reg_sign),
    .exponent_o       (reg_exponent),
    .product_o        (reg_product),
    .rnd_mode_o       (reg_rnd_mode)
  );

  fmul_round_stage round_stage_i (
    .special_i        (reg_special),
    .special_result_i (reg_special_result),
    .special_status_i (reg_special_status),
    .sign_i           (reg_sign),
    .exponent_i       (reg_exponent),
    .product_i        (reg_product),
    .rnd_mode_i       (reg_rnd_mode),
    .result_o         (result_o),
    .status_o         (status_o)
  );

endmodule

//--- tb/fmul_properties.sv
// ----------------------------------------
// Binary16 multiplier output properties
// Flag consistency and reset behavior
// ----------------------------------------
`timescale 1ns/1ps
`include "fmul_config.svh"

module fmul_properties (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic [`FMUL_WIDTH-1:0] result_i,
  input fmul_pkg::status_t      status_i
);

  localparam logic [`FMUL_WIDTH-1:0] QNAN =
    {1'b0, {`FMUL_EXP_BITS{1'b1}}, 1'b1, {(`FMUL_MAN_BITS-1){1'b0}}};

  // Count of failed assertions
  int fail_count = 0;

  // Invalid operation always returns the canonical qNaN
  nv_gives_qnan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    status_i.NV |-> (result_i == QNAN))
    else begin
      fail_count++;
      $error("NV set with result %h", result_i);
    end

  // Overflow is always inexact
  of_implies_nx: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    status_i.OF |-> status_i.NX)
    else begin
      fail_count++;
      $error("OF set without NX");
    end

  // Underflow only reported for inexact results
  uf_implies_nx: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    status_i.UF |-> status_i.NX)
    else begin
      fail_count++;
      $error("UF set without NX");
    end

  // Cleared register gives clear flags
  reset_status_clear: assert property (@(posedge clk_i)
    !rst_n_i |-> (status_i == '0))
    else begin
      fail_count++;
      $error("Flags %b during reset", status_i);
    end

endmodule

bind fmul_top fmul_properties properties_i (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .result_i (result_o),
  .status_i (status_o)
);

//--- tb/fmul_tb.sv
// ----------------------------------------
// Binary16 multiplier testbench
// Directed and random products checked
// against a reference model, one cycle late
// ----------------------------------------
`timescale 1ns/1ps
`include "fmul_config.svh"

module fmul_tb;

  import fmul_pkg::*;

  localparam int MAN           = `FMUL_MAN_BITS;
  localparam int BIAS          = `FMUL_BIAS;
  localparam int EXP_MAX       = (1 << `FMUL_EXP_BITS) - 1;
  localparam int HIDDEN        = 1 << MAN;
  // Smallest quantum, the weight of the subnormal LSB
  localparam int QMIN          = 1 - BIAS - MAN;
  localparam int DRAIN_TIMEOUT = 16;
  localparam int RANDOM_OPS    = 2000;

  typedef struct packed {
    fp16_u   result;
    status_t status;
  } expected_t;

  // One operation in flight between driver and compare
  typedef struct {
    logic [`FMUL_WIDTH-1:0] a;
    logic [`FMUL_WIDTH-1:0] b;
    roundmode_e             mode;
    expected_t              expected;
    int                     issue_edge;
  } pending_t;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  logic [`FMUL_WIDTH-1:0] operand_a_i;
  logic [`FMUL_WIDTH-1:0] operand_b_i;
  roundmode_e             rnd_mode_i;
  logic [`FMUL_WIDTH-1:0] result_o;
  status_t                status_o;

  pending_t    pending_q[$];
  logic [31:0] pair_q[$];
  int          edge_count = 0;
  int          checks     = 0;
  int          errors     = 0;
  int          tests_run  = 0;

  fmul_top fmul_top_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .rnd_mode_i  (rnd_mode_i),
    .result_o    (result_o),
    .status_o    (status_o)
  );

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) edge_count <= edge_count + 1;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic fp_class_t classify_operand(input fp16_u x);
    fp_class_t c;
    c = '0;
    if (x.fields.exponent == EXP_MAX) begin
      c.is_inf        = (x.fields.mantissa == 0);
      c.is_nan        = (x.fields.mantissa != 0);
      // Clear quiet bit marks a signalling NaN
      c.is_signalling = c.is_nan && !x.fields.mantissa[MAN-1];
    end else if (x.fields.exponent == 0) begin
      c.is_zero      = (x.fields.mantissa == 0);
      c.is_subnormal = (x.fields.mantissa != 0);
    end else begin
      c.is_normal = 1'b1;
    end
    return c;
  endfunction

  // Right shift by s with rounding, s <= 0 is an exact left shift
  function automatic longint shift_round(input longint m, input int s, input roundmode_e mode,
                                         input logic sign, output logic inexact);
    longint kept;
    longint rem;
    longint half;
    logic   up;
    inexact = 1'b0;
    if (s <= 0) begin
      return m << (-s);
    end
    kept    = m >> s;
    rem     = m - (kept << s);
    half    = longint'(1) << (s - 1);
    inexact = (rem != 0);
    case (mode)
      RNE:     up = (rem > half) || ((rem == half) && (kept % 2 == 1));
      RTZ:     up = 1'b0;
      RDN:     up = inexact && sign;
      RUP:     up = inexact && !sign;
      RMM:     up = (rem >= half);
      default: up = 1'b0;
    endcase
    return kept + (up ? 1 : 0);
  endfunction

  function automatic expected_t reference_mul(input fp16_u a, input fp16_u b,
                                              input roundmode_e mode);
    expected_t res;
    fp_class_t ca;
    fp_class_t cb;
    logic      sign;
    logic      inexact;
    logic      unb_inexact;
    logic      tiny;
    logic      to_inf;
    longint    m;
    longint    t;
    longint    tu;
    int        e;
    int        msb;
    int        q;
    int        biased;
    ca         = classify_operand(a);
    cb         = classify_operand(b);
    sign       = a.fields.sign ^ b.fields.sign;
    res.status = '0;
    // Canonical quiet NaN
    res.result.raw = {1'b0, {`FMUL_EXP_BITS{1'b1}}, 1'b1, {(MAN-1){1'b0}}};
    if ((ca.is_inf && cb.is_zero) || (ca.is_zero && cb.is_inf)) begin
      res.status.NV = 1'b1;
      return res;
    end
    if (ca.is_nan || cb.is_nan) begin
      res.status.NV = ca.is_signalling || cb.is_signalling;
      return res;
    end
    if (ca.is_inf || cb.is_inf) begin
      res.result.raw = {sign, {`FMUL_EXP_BITS{1'b1}}, {MAN{1'b0}}};
      return res;
    end
    // Exact value is m * 2^e with integer significands
    m = (ca.is_normal ? HIDDEN + a.fields.mantissa : a.fields.mantissa)
      * (cb.is_normal ? HIDDEN + b.fields.mantissa : b.fields.mantissa);
    e = (ca.is_normal ? int'(a.fields.exponent) : 1)
      + (cb.is_normal ? int'(b.fields.exponent) : 1) - 2 * (BIAS + MAN);
    if (m == 0) begin
      res.result.raw = {sign, {(`FMUL_WIDTH-1){1'b0}}};
      return res;
    end
    msb = 0;
    for (int i = 0; i < `FMUL_PROD_WIDTH; i++) begin
      if ((m >> i) & 1) msb = i;
    end
    // Result quantum, never below the subnormal LSB
    q = (msb + e - MAN < QMIN) ? QMIN : msb + e - MAN;
    t = shift_round(m, q - e, mode, sign, inexact);
    if (t >= 2 * HIDDEN) begin
      t = t >> 1;
      q++;
    end
    biased = (t >= HIDDEN) ? q + MAN + BIAS : 0;
    // Tininess with unbounded exponent, after rounding
    tu   = shift_round(m, msb - MAN, mode, sign, unb_inexact);
    tiny = (msb + e + ((tu >= 2 * HIDDEN) ? 1 : 0)) < 1 - BIAS;
    if (biased >= EXP_MAX) begin
      res.status.OF = 1'b1;
      res.status.NX = 1'b1;
      to_inf = (mode == RNE) || (mode == RMM) || ((mode == RUP) && !sign)
            || ((mode == RDN) && sign);
      if (to_inf) begin
        res.result.raw = {sign, {`FMUL_EXP_BITS{1'b1}}, {MAN{1'b0}}};
      end else begin
        res.result.raw = {sign, `FMUL_EXP_BITS'(EXP_MAX - 1), {MAN{1'b1}}};
      end
      return res;
    end
    res.result.raw = {sign, `FMUL_EXP_BITS'(biased), MAN'(t)};
    res.status.NX  = inexact;
    res.status.UF  = tiny && inexact;
    return res;
  endfunction

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  function automatic string describe(input pending_t p);
    return $sformatf("%h * %h in %s", p.a, p.b, p.mode.name());
  endfunction

  task automatic check_result(input fp16_u got, input fp16_u expected, input string what);
    checks++;
    if (got.raw !== expected.raw) begin
      errors++;
      $display("CHECK FAILED at %0t: %s gave result %h, expected %h",
               $time, what, got.raw, expected.raw);
    end
  endtask

  task automatic check_status(input status_t got, input status_t expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s gave flags NV OF UF NX %b, expected %b",
               $time, what, got, expected);
    end
  endtask

  // Result of an item is in the register one edge after it was driven
  always @(negedge clk_i) begin : compare
    pending_t entry;
    fp16_u    got;
    if ((pending_q.size() > 0) && (pending_q[0].issue_edge + 1 < edge_count)) begin
      entry   = pending_q.pop_front();
      got.raw = result_o;
      check_result(got, entry.expected.result, describe(entry));
      check_status(status_o, entry.expected.status, describe(entry));
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic apply_op(input logic [`FMUL_WIDTH-1:0] a, input logic [`FMUL_WIDTH-1:0] b,
                          input roundmode_e mode);
    pending_t entry;
    @(posedge clk_i);
    operand_a_i <= a;
    operand_b_i <= b;
    rnd_mode_i  <= mode;
    entry.a          = a;
    entry.b          = b;
    entry.mode       = mode;
    entry.expected   = reference_mul(a, b, mode);
    entry.issue_edge = edge_count;
    pending_q.push_back(entry);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending_q.size() != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        $display("Timeout: %0d results still unchecked", pending_q.size());
        $display("sim failed");
        $finish;
      end
    end
  endtask

  task automatic finish_test(input string name, input int first_check, input int first_error);
    wait_drain();
    tests_run++;
    $display("test %-16s %0d checks, %0d errors", name, checks - first_check,
             errors - first_error);
  endtask

  // Every pair of pair_q in all five modes
  task automatic run_directed(input string name);
    int first_check;
    int first_error;
    first_check = checks;
    first_error = errors;
    foreach (pair_q[i]) begin
      for (int m = 0; m < 5; m++) begin
        apply_op(pair_q[i][31:16], pair_q[i][15:0], roundmode_e'(m));
      end
    end
    finish_test(name, first_check, first_error);
  endtask

  task automatic run_random(input int count);
    int first_check;
    int first_error;
    first_check = checks;
    first_error = errors;
    for (int i = 0; i < count; i++) begin
      apply_op(16'($urandom), 16'($urandom), roundmode_e'($urandom_range(4, 0)));
    end
    finish_test("random", first_check, first_error);
  endtask

  initial begin : main
    int assert_fails;
    void'($urandom(63195));
    rst_n_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    rnd_mode_i  = RNE;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Small integers and powers of two
    pair_q = {32'h4000_4200, 32'h3800_C400, 32'h3E00_3E00, 32'h4700_4500,
              32'h3400_3000, 32'hC900_C900, 32'h5800_2C00};
    run_directed("exact_products");
    // Invalid, NaN, infinity and zero operands
    pair_q = {32'h7C00_0000, 32'h0000_FC00, 32'h7E01_3C00, 32'h3C00_7D00,
              32'h7C00_C000, 32'hFC00_3555, 32'h8000_4500, 32'h0000_C200,
              32'h7C01_7C00};
    run_directed("special_cases");
    // First three are exact ties
    pair_q = {32'h3C01_3E00, 32'h3C03_3E00, 32'hBC01_3E00, 32'h3555_4155,
              32'h3C01_3C01, 32'h4248_C0AA, 32'h2E66_5133};
    run_directed("inexact_rounding");
    // Overflow, then subnormal and underflow boundary cases
    pair_q = {32'h7BFF_4000, 32'h7000_7000, 32'hF800_5800, 32'h7BFF_3C01,
              32'h5BFF_5C00, 32'h0400_3800, 32'h0401_3800, 32'h0001_3800,
              32'h0001_0001, 32'h3BFF_0400, 32'hBBFE_0401, 32'h03FF_3C01,
              32'h0003_3400};
    run_directed("range_limits");
    run_random(RANDOM_OPS);

    assert_fails = fmul_top_i.properties_i.fail_count;
    $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, checks, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/fmul_pkg.sv
design/fmul_operand_stage.sv
design/fmul_stage_reg.sv
design/fmul_round_stage.sv
design/fmul_top.sv
tb/fmul_properties.sv
tb/fmul_tb.sv
